// File: Makefile
SIM ?= verilator
FLAGS ?= --binary --timing -Wno-fatal
TOP ?= fftCoreTb
FILELIST ?= sources.f
OBJDIR ?= obj_dir
LOG ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: include/fft_settings.svh
// Sizes and fixed-point format for the 8-point FFT core
// Twiddles carry FRAC_BITS fraction bits and one spare integer bit so that 1.0 fits
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

// Transform size
`define FFT_POINTS 8
`define FFT_LOG_POINTS 3

// Word widths
`define SAMPLE_WIDTH 8
`define DATA_WIDTH 16
`define FRAC_BITS 7
`define TWIDDLE_WIDTH (`FRAC_BITS + 2)

// Ping-pong buffers, also the initial credit count
`define BUFFER_COUNT 2

`endif

// File: sources.f
+incdir+include
verilog/fftPkg.sv
verilog/ramPortIf.sv
verilog/sampleLoader.sv
verilog/butterflyUnit.sv
verilog/butterflyEngine.sv
verilog/bufferBank.sv
verilog/fftCore.sv
verif/fftCoreTb.sv

// File: verif/fftCoreTb.sv
// Drives fftCore with frames from verif/fft_patterns.hex and checks the real bins of the last result
// Every sample requests a frame, so only the final result of a frame is compared with the file
`default_nettype none

`include "fft_settings.svh"

module fftCoreTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FrameCount = 5;
	localparam int WordsPerFrame = 2 * `FFT_POINTS;
	localparam int QuietCycles = 80;
	localparam int FrameSends = 10;
	// Every sample requests a frame of its own
	localparam int FrameRequests = FrameSends * `FFT_POINTS;
	localparam int CyclesPerFrame = 40;
	localparam int TimeoutCycles = CyclesPerFrame * FrameRequests + 200;

	logic clk;
	logic reset;
	logic sampleValid;
	fftPkg::sample_t sampleIn;
	fftPkg::addr_t readAddress;
	logic resultRelease;
	logic resultValid;
	fftPkg::data_t resultData;

	fftPkg::data_t patterns [FrameCount * WordsPerFrame];
	fftPkg::data_t lastBins [`FFT_POINTS];
	int validCount;
	int handledCount;
	int cycleCount;
	int errorCount;
	int checksDone;
	int testCount;
	int testErrors;
	int base;
	bit sendDone;

	fftCore dut0 (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleIn(sampleIn),
		.readAddress(readAddress),
		.resultRelease(resultRelease),
		.resultValid(resultValid),
		.resultData(resultData)
	);

	always #2 clk = ~clk;

	// Pulses seen by the host, sampled before the DUT updates
	always @(posedge clk) begin
		if (reset) begin
			validCount <= 0;
		end else if (resultValid) begin
			validCount <= validCount + 1;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout: the run did not end within %0d cycles", TimeoutCycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic checkBin(input fftPkg::addr_t bin, input fftPkg::data_t expected,
			input fftPkg::data_t actual);
		checksDone++;
		if (actual !== expected) begin
			errorCount++;
			$display("** Error at %0t: bin %0d expected %0d, got %0d", $time, bin,
				expected, actual);
		end
	endtask

	task automatic checkCount(input int expected, input int actual, input string what);
		checksDone++;
		if (actual != expected) begin
			errorCount++;
			$display("** Error at %0t: %s expected %0d resultValid pulses, got %0d",
				$time, what, expected, actual);
		end
	endtask

	task automatic compareFrame(input int frame);
		for (int k = 0; k < `FFT_POINTS; k++) begin
			checkBin(fftPkg::addr_t'(k), patterns[frame * WordsPerFrame + `FFT_POINTS + k],
				lastBins[k]);
		end
	endtask

	// Shifts in the samples of consecutive frames, oldest first
	task automatic sendFrames(input int first, input int count, input bit randomGaps);
		int gap;
		for (int f = first; f < first + count; f++) begin
			for (int n = 0; n < `FFT_POINTS; n++) begin
				@(negedge clk);
				sampleValid = 1'b1;
				sampleIn = fftPkg::sample_t'(patterns[f * WordsPerFrame + n]);
				gap = randomGaps ? int'($urandom % 3) : 0;
				if (gap > 0) begin
					@(negedge clk);
					sampleValid = 1'b0;
					repeat (gap - 1) @(negedge clk);
				end
			end
		end
		@(negedge clk);
		sampleValid = 1'b0;
	endtask

	// Two cycles per bin; data returns one cycle after the address
	task automatic readBins();
		for (int k = 0; k < `FFT_POINTS; k++) begin
			@(negedge clk);
			readAddress = fftPkg::addr_t'(k);
			@(negedge clk);
			lastBins[k] = resultData;
		end
	endtask

	task automatic releaseResult();
		@(negedge clk);
		resultRelease = 1'b1;
		@(negedge clk);
		resultRelease = 1'b0;
	endtask

	task automatic waitForPulses(input int target);
		while (validCount < target) begin
			@(negedge clk);
		end
	endtask

	// Reads and frees every result until the DUT stays quiet after sending ends
	task automatic serviceResults();
		int quiet;
		quiet = 0;
		while (!(sendDone && quiet >= QuietCycles)) begin
			@(negedge clk);
			if (validCount > handledCount) begin
				readBins();
				releaseResult();
				handledCount++;
				quiet = 0;
			end else begin
				quiet++;
			end
		end
	endtask

	task automatic runFrames(input int first, input int count, input bit randomGaps);
		sendDone = 1'b0;
		fork
			begin
				sendFrames(first, count, randomGaps);
				sendDone = 1'b1;
			end
			serviceResults();
		join
	endtask

	task automatic startTest();
		testErrors = errorCount;
		base = validCount;
		handledCount = validCount;
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("Test %s finished with %0d errors", name, errorCount - testErrors);
	endtask

	initial begin
		void'($urandom(32'h3d88));
		$readmemh("verif/fft_patterns.hex", patterns);
		clk = 1'b0;
		reset = 1'b1;
		sampleValid = 1'b0;
		sampleIn = '0;
		readAddress = '0;
		resultRelease = 1'b0;
		cycleCount = 0;
		errorCount = 0;
		checksDone = 0;
		testCount = 0;
		handledCount = 0;
		sendDone = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		startTest();
		repeat (30) @(negedge clk);
		checkCount(0, validCount - base, "idle after reset");
		finishTest("reset");

		startTest();
		runFrames(0, 1, 1'b0);
		compareFrame(0);
		finishTest("impulse");

		for (int f = 1; f < FrameCount; f++) begin
			startTest();
			runFrames(f, 1, 1'b1);
			compareFrame(f);
			finishTest($sformatf("pattern frame %0d", f));
		end

		// Both buffers fill, the last request waits for a credit
		startTest();
		sendFrames(2, 3, 1'b1);
		repeat (150) @(negedge clk);
		checkCount(2, validCount - base, "without release");
		releaseResult();
		waitForPulses(base + 3);
		releaseResult();
		readBins();
		compareFrame(4);
		releaseResult();
		repeat (QuietCycles) @(negedge clk);
		checkCount(3, validCount - base, "after releases");
		handledCount = validCount;
		finishTest("back-pressure");

		startTest();
		runFrames(2, 2, 1'b0);
		compareFrame(3);
		checksDone++;
		if (handledCount - base < 2) begin
			errorCount++;
			$display("Two frames in flight gave only %0d results", handledCount - base);
		end
		finishTest("two frames in flight");

		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checksDone, errorCount);
		if (errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/fft_patterns.hex
// Per frame: 8 samples in send order (first is oldest), sign-extended to 16 bits
// then the 8 expected real bins 0 to 7
// Frame 0, impulse in the oldest position
0001 0000 0000 0000 0000 0000 0000 0000
0080 005b 0000 ffa5 ff80 ffa5 0000 005b
// Frame 1, constant
0001 0001 0001 0001 0001 0001 0001 0001
0400 0000 0000 0000 0000 0000 0000 0000
// Frame 2, ramp
0001 0002 0003 0004 0005 0006 0007 0008
1200 0200 0200 0200 0200 0200 0200 0200
// Frame 3, mixed signs
000a fffd 0000 0007 ffec 0005 0002 fff8
fc80 03e0 fe80 ed20 0480 ed20 fe80 03e0
// Frame 4, step
ffff ffff ffff ffff 0001 0001 0001 0001
0000 0100 0000 0100 0000 0100 0000 0100

// File: verilog/bufferBank.sv
// Two complex buffers of FFT_POINTS words; loader and engine are steered by their pointers
// Host sees the real part of the oldest unreleased buffer, one cycle after the address
`default_nettype none

`include "fft_settings.svh"

module bufferBank (
	input logic clk,
	input logic reset,
	ramPortIf.bank loadPort,
	ramPortIf.bank computePort,
	input fftPkg::bufSel_t loadBuffer,
	input fftPkg::bufSel_t computeBuffer,
	input logic resultRelease,
	input fftPkg::addr_t readAddress,
	output fftPkg::data_t resultData
);

	fftPkg::data_t memReal [`BUFFER_COUNT][`FFT_POINTS];
	fftPkg::data_t memImag [`BUFFER_COUNT][`FFT_POINTS];
	fftPkg::bufSel_t readPointer;

	// Oldest unreleased result, moves on with each release
	always_ff @(posedge clk) begin
		if (reset) begin
			readPointer <= '0;
		end else if (resultRelease) begin
			readPointer <= readPointer + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (loadPort.writeEnable) begin
			memReal[loadBuffer][loadPort.addressA] <= loadPort.writeRealA;
			memImag[loadBuffer][loadPort.addressA] <= loadPort.writeImagA;
			memReal[loadBuffer][loadPort.addressB] <= loadPort.writeRealB;
			memImag[loadBuffer][loadPort.addressB] <= loadPort.writeImagB;
		end
		if (computePort.writeEnable) begin
			memReal[computeBuffer][computePort.addressA] <= computePort.writeRealA;
			memImag[computeBuffer][computePort.addressA] <= computePort.writeImagA;
			memReal[computeBuffer][computePort.addressB] <= computePort.writeRealB;
			memImag[computeBuffer][computePort.addressB] <= computePort.writeImagB;
		end
	end

	// Synchronous reads, old data on a same-cycle write
	always_ff @(posedge clk) begin
		computePort.readRealA <= memReal[computeBuffer][computePort.addressA];
		computePort.readImagA <= memImag[computeBuffer][computePort.addressA];
		computePort.readRealB <= memReal[computeBuffer][computePort.addressB];
		computePort.readImagB <= memImag[computeBuffer][computePort.addressB];
		resultData <= memReal[readPointer][readAddress];
	end

	// Loader and engine never share a buffer while both write
	assert property (@(posedge clk) disable iff (reset)
		(loadPort.writeEnable && computePort.writeEnable) |-> loadBuffer != computeBuffer)
		else $error("bufferBank: loader and engine write the same buffer");

endmodule

`default_nettype wire

// File: verilog/butterflyEngine.sv
// In-place decimation-in-time FFT over a bit-reversed buffer, one butterfly per 2 cycles
// Counts at most BUFFER_COUNT loaded frames; the loader's credits keep it within that
`default_nettype none

`include "fft_settings.svh"

module butterflyEngine (
	input logic clk,
	input logic reset,
	input logic frameLoaded,
	ramPortIf.requester computePort,
	output fftPkg::bufSel_t computeBuffer,
	output logic resultValid
);

	localparam int IndexWidth = `FFT_LOG_POINTS - 1;
	localparam int LastStage = `FFT_LOG_POINTS - 1;

	fftPkg::engineState_t state;
	logic [1:0] loadedCount;
	logic [$clog2(`FFT_LOG_POINTS)-1:0] stage;
	logic [IndexWidth-1:0] butterfly;
	logic [IndexWidth-1:0] position;
	logic [IndexWidth-1:0] group;
	logic [IndexWidth-1:0] twiddleIndex;
	fftPkg::addr_t halfSpan;
	fftPkg::addr_t addressA;
	logic startFrame;
	logic lastButterfly;
	fftPkg::data_t upperReal;
	fftPkg::data_t upperImag;
	fftPkg::data_t lowerReal;
	fftPkg::data_t lowerImag;

	// Butterfly addressing for stage s
	always_comb begin
		halfSpan = fftPkg::addr_t'(1) << stage;
		position = butterfly & IndexWidth'(halfSpan - 1'b1);
		group = butterfly >> stage;
		addressA = (fftPkg::addr_t'(group) << (stage + 1'b1)) | fftPkg::addr_t'(position);
		twiddleIndex = position << (LastStage - stage);
	end

	assign startFrame = (state == fftPkg::idle) && (loadedCount != '0);
	assign lastButterfly = (butterfly == '1) && (stage == LastStage);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fftPkg::idle;
			loadedCount <= '0;
			stage <= '0;
			butterfly <= '0;
			computeBuffer <= '0;
			resultValid <= 1'b0;
		end else begin
			loadedCount <= loadedCount + 2'(frameLoaded) - 2'(startFrame);
			resultValid <= 1'b0;
			case (state)
				fftPkg::idle: begin
					if (startFrame) begin
						state <= fftPkg::read;
						stage <= '0;
						butterfly <= '0;
					end
				end
				fftPkg::read: begin
					state <= fftPkg::write;
				end
				fftPkg::write: begin
					butterfly <= butterfly + 1'b1;
					if (lastButterfly) begin
						state <= fftPkg::idle;
						resultValid <= 1'b1;
						computeBuffer <= computeBuffer + 1'b1;
					end else begin
						state <= fftPkg::read;
						if (butterfly == '1) begin
							stage <= stage + 1'b1;
						end
					end
				end
				default: begin
					state <= fftPkg::idle;
				end
			endcase
		end
	end

	butterflyUnit butterflyUnit0 (
		.aReal(computePort.readRealA),
		.aImag(computePort.readImagA),
		.bReal(computePort.readRealB),
		.bImag(computePort.readImagB),
		.wReal(fftPkg::twiddleReal[twiddleIndex]),
		.wImag(fftPkg::twiddleImag[twiddleIndex]),
		.upperReal(upperReal),
		.upperImag(upperImag),
		.lowerReal(lowerReal),
		.lowerImag(lowerImag)
	);

	// Results go back to the addresses they came from
	always_comb begin
		computePort.addressA = addressA;
		computePort.addressB = addressA + halfSpan;
		computePort.writeEnable = (state == fftPkg::write);
		computePort.writeRealA = upperReal;
		computePort.writeImagA = upperImag;
		computePort.writeRealB = lowerReal;
		computePort.writeImagB = lowerImag;
	end

	// Loader credits bound the frames waiting here
	assert property (@(posedge clk) disable iff (reset) loadedCount <= `BUFFER_COUNT)
		else $error("butterflyEngine: more loaded frames than buffers");

endmodule

`default_nettype wire

// File: verilog/butterflyUnit.sv
// Fixed-point radix-2 butterfly, purely combinational
// b drops its fraction bits before the product, results wrap at DATA_WIDTH
`default_nettype none

`include "fft_settings.svh"

module butterflyUnit (
	input fftPkg::data_t aReal,
	input fftPkg::data_t aImag,
	input fftPkg::data_t bReal,
	input fftPkg::data_t bImag,
	input fftPkg::twiddle_t wReal,
	input fftPkg::twiddle_t wImag,
	output fftPkg::data_t upperReal,
	output fftPkg::data_t upperImag,
	output fftPkg::data_t lowerReal,
	output fftPkg::data_t lowerImag
);

	localparam int ProductWidth = `DATA_WIDTH + `TWIDDLE_WIDTH;

	fftPkg::data_t bRealScaled;
	fftPkg::data_t bImagScaled;
	logic signed [ProductWidth-1:0] productReal;
	logic signed [ProductWidth-1:0] productImag;
	fftPkg::data_t wbReal;
	fftPkg::data_t wbImag;

	always_comb begin
		bRealScaled = bReal >>> `FRAC_BITS;
		bImagScaled = bImag >>> `FRAC_BITS;

		// Complex product w * b, back in the data format
		productReal = bRealScaled * wReal - bImagScaled * wImag;
		productImag = bRealScaled * wImag + bImagScaled * wReal;
		wbReal = fftPkg::data_t'(productReal);
		wbImag = fftPkg::data_t'(productImag);

		upperReal = aReal + wbReal;
		upperImag = aImag + wbImag;
		lowerReal = aReal - wbReal;
		lowerImag = aImag - wbImag;
	end

endmodule

`default_nettype wire

// File: verilog/fftCore.sv
// 8-point real-input FFT core with a two-buffer result store
// Host must pulse resultRelease once per result, or loading stops after two frames
`default_nettype none

module fftCore (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input fftPkg::sample_t sampleIn,
	input fftPkg::addr_t readAddress,
	input logic resultRelease,
	output logic resultValid,
	output fftPkg::data_t resultData
);

	fftPkg::bufSel_t loadBuffer;
	fftPkg::bufSel_t computeBuffer;
	logic frameLoaded;

	ramPortIf loadPort ();
	ramPortIf computePort ();

	sampleLoader sampleLoader0 (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleIn(sampleIn),
		.resultRelease(resultRelease),
		.loadPort(loadPort.requester),
		.loadBuffer(loadBuffer),
		.frameLoaded(frameLoaded)
	);

	butterflyEngine butterflyEngine0 (
		.clk(clk),
		.reset(reset),
		.frameLoaded(frameLoaded),
		.computePort(computePort.requester),
		.computeBuffer(computeBuffer),
		.resultValid(resultValid)
	);

	// Shared RAM for loading, computing and the host read
	bufferBank bufferBank0 (
		.clk(clk),
		.reset(reset),
		.loadPort(loadPort.bank),
		.computePort(computePort.bank),
		.loadBuffer(loadBuffer),
		.computeBuffer(computeBuffer),
		.resultRelease(resultRelease),
		.readAddress(readAddress),
		.resultData(resultData)
	);

endmodule

`default_nettype wire

// File: verilog/fftPkg.sv
// Types shared by the FFT core and its testbench
// The twiddle table is written out for 8 points and must be redone if FFT_POINTS changes
`default_nettype none

`include "fft_settings.svh"

package fftPkg;

	typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;
	typedef logic signed [`DATA_WIDTH-1:0] data_t;
	typedef logic signed [`TWIDDLE_WIDTH-1:0] twiddle_t;
	typedef logic [`FFT_LOG_POINTS-1:0] addr_t;
	typedef logic [0:0] bufSel_t;
	typedef logic [1:0] credit_t;

	typedef enum logic [1:0] {
		idle,
		read,
		write
	} engineState_t;

	// W^k = cos(2*pi*k/8) - j*sin(2*pi*k/8), times 128 and rounded
	localparam twiddle_t twiddleReal [`FFT_POINTS/2] = '{
		twiddle_t'(128),
		twiddle_t'(91),
		twiddle_t'(0),
		twiddle_t'(-91)
	};

	localparam twiddle_t twiddleImag [`FFT_POINTS/2] = '{
		twiddle_t'(0),
		twiddle_t'(-91),
		twiddle_t'(-128),
		twiddle_t'(-91)
	};

endpackage

`default_nettype wire

// File: verilog/ramPortIf.sv
// One two-port RAM access path; ports A and B share a single write enable
// Read data is registered and returns one cycle after the address
`default_nettype none

interface ramPortIf;

	fftPkg::addr_t addressA;
	fftPkg::addr_t addressB;
	logic writeEnable;

	// Write data, real and imaginary per port
	fftPkg::data_t writeRealA;
	fftPkg::data_t writeImagA;
	fftPkg::data_t writeRealB;
	fftPkg::data_t writeImagB;

	// Read data from the bank
	fftPkg::data_t readRealA;
	fftPkg::data_t readImagA;
	fftPkg::data_t readRealB;
	fftPkg::data_t readImagB;

	modport requester (
		output addressA, addressB, writeEnable,
		output writeRealA, writeImagA, writeRealB, writeImagB,
		input readRealA, readImagA, readRealB, readImagB
	);

	modport bank (
		input addressA, addressB, writeEnable,
		input writeRealA, writeImagA, writeRealB, writeImagB,
		output readRealA, readImagA, readRealB, readImagB
	);

endinterface

`default_nettype wire

// File: verilog/sampleLoader.sv
// Window of the newest samples; window[0] is the newest and becomes x[0] of the transform
// Every sample requests a frame, requests merge while a copy runs or no credit is left
`default_nettype none

`include "fft_settings.svh"

module sampleLoader (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input fftPkg::sample_t sampleIn,
	input logic resultRelease,
	ramPortIf.requester loadPort,
	output fftPkg::bufSel_t loadBuffer,
	output logic frameLoaded
);

	localparam int CopyWidth = `FFT_LOG_POINTS - 1;

	fftPkg::sample_t window [`FFT_POINTS];
	fftPkg::sample_t snapshot [`FFT_POINTS];
	logic requestPending;
	logic copying;
	logic startCopy;
	logic [CopyWidth-1:0] copyCount;
	fftPkg::credit_t credits;
	fftPkg::addr_t addressA;
	fftPkg::addr_t addressB;

	function automatic fftPkg::addr_t bitReverse(input fftPkg::addr_t index);
		fftPkg::addr_t reversed;
		for (int i = 0; i < `FFT_LOG_POINTS; i++) begin
			reversed[i] = index[`FFT_LOG_POINTS-1-i];
		end
		return reversed;
	endfunction

	// Sample into internal format, integer part above the fraction bits
	function automatic fftPkg::data_t widen(input fftPkg::sample_t sample);
		return fftPkg::data_t'(sample) <<< `FRAC_BITS;
	endfunction

	assign startCopy = requestPending && !copying && (credits != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `FFT_POINTS; i++) begin
				window[i] <= '0;
			end
		end else if (sampleValid) begin
			window[0] <= sampleIn;
			for (int i = 1; i < `FFT_POINTS; i++) begin
				window[i] <= window[i-1];
			end
		end
	end

	// Frame contents frozen when the copy starts
	always_ff @(posedge clk) begin
		if (startCopy) begin
			snapshot <= window;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			requestPending <= 1'b0;
			copying <= 1'b0;
			copyCount <= '0;
			credits <= fftPkg::credit_t'(`BUFFER_COUNT);
			loadBuffer <= '0;
			frameLoaded <= 1'b0;
		end else begin
			// A sample in the start cycle leaves a fresh request behind
			requestPending <= sampleValid || (requestPending && !startCopy);
			credits <= credits - fftPkg::credit_t'(startCopy)
				+ fftPkg::credit_t'(resultRelease);
			frameLoaded <= 1'b0;
			if (startCopy) begin
				copying <= 1'b1;
				copyCount <= '0;
			end else if (copying) begin
				copyCount <= copyCount + 1'b1;
				if (copyCount == '1) begin
					copying <= 1'b0;
					frameLoaded <= 1'b1;
					loadBuffer <= loadBuffer + 1'b1;
				end
			end
		end
	end

	// Two neighbouring addresses per cycle
	assign addressA = {copyCount, 1'b0};
	assign addressB = {copyCount, 1'b1};

	always_comb begin
		loadPort.addressA = addressA;
		loadPort.addressB = addressB;
		loadPort.writeEnable = copying;
		loadPort.writeRealA = widen(snapshot[bitReverse(addressA)]);
		loadPort.writeImagA = '0;
		loadPort.writeRealB = widen(snapshot[bitReverse(addressB)]);
		loadPort.writeImagB = '0;
	end

	// Host never releases more buffers than it was handed
	assert property (@(posedge clk) disable iff (reset) credits <= `BUFFER_COUNT)
		else $error("sampleLoader: credit count above buffer count");

endmodule

`default_nettype wire
